//--- hw/cpuPkg.sv
package cpuPkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int dataWidth         = 16; // Data and address word
  localparam int regAddrWidth      = 4;  // Sixteen registers
  localparam int numRegs           = 2 ** regAddrWidth;
  localparam int branchOffsetWidth = 9;  // Signed word offset
  localparam int immWidth          = 8;  // LLB immediate

  // Run/halted FSM encoding
  localparam logic stateRun    = 1'b0;
  localparam logic stateHalted = 1'b1;

  typedef logic [dataWidth-1:0]    word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // Codes 8 to 11, 13 and 14 are no-ops
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    NOR = 4'd3,
    SLL = 4'd4,
    SRL = 4'd5,
    SRA = 4'd6,
    LLB = 4'd7,
    BR  = 4'd12,
    HLT = 4'd15
  } opcode_t;

  typedef enum logic [2:0] {NE, EQ, GT, LT, GE, LE, OV, ALWAYS} cond_t;

  // One instruction word, two ways of reading it
  typedef union packed {
    struct packed {
      opcode_t  opcode;
      regAddr_t rd;
      regAddr_t rs; // Upper immediate nibble for LLB
      regAddr_t rt; // Shift amount for shifts
    } regView;
    struct packed {
      opcode_t                      opcode;
      cond_t                        cond;
      logic [branchOffsetWidth-1:0] offset;
    } brView;
  } instr_u;

  typedef struct packed {
    logic zero;
    logic overflow;
    logic negative;
  } flags_t;

endpackage

//--- hw/pcUnit.sv
`timescale 1ns/10ps

module pcUnit (
  input  logic          clk,
  input  logic          rstN,
  input  logic          branchTaken,
  input  cpuPkg::word_t branchTarget,
  input  logic          halted,
  output cpuPkg::word_t pc
);

  cpuPkg::word_t pcNext; // Value for the next edge

  ////////////////////
  // Next address
  ////////////////////
  always_comb begin
    if (branchTaken) begin
      pcNext = branchTarget; // Resolved in execute
    end else if (halted) begin
      pcNext = pc;           // Frozen for good
    end else begin
      pcNext = pc + cpuPkg::word_t'(1);
    end
  end

  // Program counter
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

//--- hw/pipeControl.sv
`timescale 1ns/10ps

module pipeControl (
  input  logic clk,
  input  logic rstN,
  input  logic branchTaken,
  input  logic haltSeen,
  output logic flush,
  output logic halted
);

  logic state;     // Run or Halted
  logic stateNext;

  ////////////////////
  // Run/halted FSM
  ////////////////////
  always_comb begin
    stateNext = state;
    case (state)
      cpuPkg::stateRun: begin
        if (haltSeen) begin
          stateNext = cpuPkg::stateHalted; // HLT reached execute
        end
      end
      default: begin
        stateNext = cpuPkg::stateHalted; // Only reset leaves
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= cpuPkg::stateRun;
    end else begin
      state <= stateNext;
    end
  end

  assign halted = (state == cpuPkg::stateHalted); // One cycle after haltSeen

  // Kills the two younger instructions in fetch/decode and decode/execute
  assign flush = branchTaken | haltSeen | halted;

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::regAddr_t rsAddr,
  input  cpuPkg::regAddr_t rtAddr,
  input  logic             wrEn,
  input  cpuPkg::regAddr_t wrAddr,
  input  cpuPkg::word_t    wrData,
  output cpuPkg::word_t    rsData,
  output cpuPkg::word_t    rtData
);

  cpuPkg::word_t regs [cpuPkg::numRegs];

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < cpuPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData; // R0 stays zero
    end
  end

  // Read ports, write-through on address match
  assign rsData = (rsAddr == '0) ? '0 :
                  (wrEn && (wrAddr == rsAddr)) ? wrData : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 :
                  (wrEn && (wrAddr == rtAddr)) ? wrData : regs[rtAddr];

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::instr_u   instr,
  input  cpuPkg::word_t    pc,
  input  logic             flush,
  input  cpuPkg::word_t    rsData,
  input  cpuPkg::word_t    rtData,
  output cpuPkg::regAddr_t rsAddr,
  output cpuPkg::regAddr_t rtAddr,
  output logic             exValid,
  output cpuPkg::opcode_t  exOp,
  output cpuPkg::regAddr_t exRd,
  output cpuPkg::regAddr_t exRs,
  output cpuPkg::regAddr_t exRt,
  output cpuPkg::word_t    exA,
  output cpuPkg::word_t    exB,
  output cpuPkg::word_t    exImm,
  output cpuPkg::cond_t    exCond,
  output cpuPkg::word_t    exTarget
);

  // Fetch/decode register
  cpuPkg::instr_u fdInstr;
  cpuPkg::word_t  fdPc;
  logic           fdValid;

  logic [cpuPkg::immWidth-1:0]          llbImm;
  logic [cpuPkg::branchOffsetWidth-1:0] brOffset;
  cpuPkg::word_t                        immExt;    // Sign-extended LLB value
  cpuPkg::word_t                        offsetExt; // Sign-extended branch offset
  cpuPkg::word_t                        target;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fdValid <= 1'b0;
    end else begin
      fdValid <= !flush; // Younger than a taken branch or HLT
    end
  end

  always_ff @(posedge clk) begin
    fdInstr <= instr;
    fdPc    <= pc;
  end

  ////////////////////
  // Decode
  ////////////////////
  assign rsAddr = fdInstr.regView.rs;
  assign rtAddr = fdInstr.regView.rt;

  // LLB immediate spans the rs and rt fields
  assign llbImm = {fdInstr.regView.rs, fdInstr.regView.rt};
  assign immExt = {{(cpuPkg::dataWidth - cpuPkg::immWidth){llbImm[cpuPkg::immWidth-1]}},
                   llbImm};

  assign brOffset  = fdInstr.brView.offset;
  assign offsetExt = {{(cpuPkg::dataWidth - cpuPkg::branchOffsetWidth)
                       {brOffset[cpuPkg::branchOffsetWidth-1]}}, brOffset};
  assign target    = fdPc + cpuPkg::word_t'(1) + offsetExt; // Relative to next address

  // Decode/execute register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
    end else begin
      exValid <= fdValid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    exOp     <= fdInstr.regView.opcode;
    exRd     <= fdInstr.regView.rd;
    exRs     <= fdInstr.regView.rs;
    exRt     <= fdInstr.regView.rt;
    exA      <= rsData;
    exB      <= rtData;
    exImm    <= immExt;
    exCond   <= fdInstr.brView.cond; // Same bits as rd[3:1]
    exTarget <= target;
  end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/10ps

module executeStage (
  input  logic             clk,
  input  logic             rstN,
  input  logic             exValid,
  input  cpuPkg::opcode_t  exOp,
  input  cpuPkg::regAddr_t exRd,
  input  cpuPkg::regAddr_t exRs,
  input  cpuPkg::regAddr_t exRt,
  input  cpuPkg::word_t    exA,
  input  cpuPkg::word_t    exB,
  input  cpuPkg::word_t    exImm,
  input  cpuPkg::cond_t    exCond,
  input  cpuPkg::word_t    exTarget,
  output logic             branchTaken,
  output cpuPkg::word_t    branchTarget,
  output logic             haltSeen,
  output logic             wbValid,
  output cpuPkg::regAddr_t wbAddr,
  output cpuPkg::word_t    wbData
);

  cpuPkg::word_t  opA, opB;    // After forwarding
  cpuPkg::word_t  aluResult;
  logic           aluOv;
  logic           setZero;     // Logic ops and shifts
  logic           setArith;    // ADD and SUB set all three
  logic           writesReg;
  logic           condMet;
  cpuPkg::flags_t flagReg;

  // Forward from writeback, wbValid already implies a nonzero wbAddr
  assign opA = (wbValid && (wbAddr == exRs)) ? wbData : exA;
  assign opB = (wbValid && (wbAddr == exRt)) ? wbData : exB;

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    aluResult = '0;
    aluOv     = 1'b0;
    setZero   = 1'b0;
    setArith  = 1'b0;
    writesReg = 1'b1;
    case (exOp)
      cpuPkg::ADD: begin
        aluResult = opA + opB; // Wraps on overflow
        aluOv     = (opA[15] == opB[15]) && (aluResult[15] != opA[15]);
        setZero   = 1'b1;
        setArith  = 1'b1;
      end
      cpuPkg::SUB: begin
        aluResult = opA - opB;
        aluOv     = (opA[15] != opB[15]) && (aluResult[15] != opA[15]);
        setZero   = 1'b1;
        setArith  = 1'b1;
      end
      cpuPkg::AND: begin aluResult = opA & opB;    setZero = 1'b1; end
      cpuPkg::NOR: begin aluResult = ~(opA | opB); setZero = 1'b1; end
      cpuPkg::SLL: begin aluResult = opA << exRt;  setZero = 1'b1; end
      cpuPkg::SRL: begin aluResult = opA >> exRt;  setZero = 1'b1; end
      cpuPkg::SRA: begin
        aluResult = cpuPkg::word_t'($signed(opA) >>> exRt); // Sign fill
        setZero   = 1'b1;
      end
      cpuPkg::LLB: aluResult = exImm; // Flags untouched
      default:     writesReg = 1'b0;  // BR, HLT, no-ops
    endcase
  end

  // Flag register, only valid flag-setting instructions update it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagReg <= '0;
    end else if (exValid) begin
      if (setZero) begin
        flagReg.zero <= (aluResult == '0);
      end
      if (setArith) begin
        flagReg.overflow <= aluOv;
        flagReg.negative <= aluResult[cpuPkg::dataWidth-1];
      end
    end
  end

  ////////////////////
  // Branch and halt
  ////////////////////
  always_comb begin
    case (exCond)
      cpuPkg::NE: condMet = !flagReg.zero;
      cpuPkg::EQ: condMet = flagReg.zero;
      cpuPkg::GT: condMet = !flagReg.zero && !flagReg.negative;
      cpuPkg::LT: condMet = flagReg.negative;
      cpuPkg::GE: condMet = flagReg.zero || !flagReg.negative;
      cpuPkg::LE: condMet = flagReg.zero || flagReg.negative;
      cpuPkg::OV: condMet = flagReg.overflow;
      default:    condMet = 1'b1; // ALWAYS
    endcase
  end

  assign branchTaken  = exValid && (exOp == cpuPkg::BR) && condMet;
  assign branchTarget = exTarget;
  assign haltSeen     = exValid && (exOp == cpuPkg::HLT);

  // Execute/writeback register, feeds the register file write port
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= exValid && writesReg && (exRd != '0); // R0 writes dropped
    end
  end

  always_ff @(posedge clk) begin
    wbAddr <= exRd;
    wbData <= aluResult;
  end

endmodule

//--- hw/cpuTop.sv
`timescale 1ns/10ps

module cpuTop (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::instr_u   instr,
  output cpuPkg::word_t    pc,
  output logic             hlt,
  output logic             wbValid,
  output cpuPkg::regAddr_t wbAddr,
  output cpuPkg::word_t    wbData
);

  logic             branchTaken, haltSeen, flush;
  cpuPkg::word_t    branchTarget;
  cpuPkg::regAddr_t rsAddr, rtAddr;
  cpuPkg::word_t    rsData, rtData;

  // Decode to execute
  logic             exValid;
  cpuPkg::opcode_t  exOp;
  cpuPkg::regAddr_t exRd, exRs, exRt;
  cpuPkg::word_t    exA, exB, exImm, exTarget;
  cpuPkg::cond_t    exCond;

  ////////////////////
  // Front end
  ////////////////////
  pcUnit u_pcUnit (
    .clk(clk), .rstN(rstN), .branchTaken(branchTaken),
    .branchTarget(branchTarget), .halted(hlt), .pc(pc)
  );

  pipeControl u_pipeControl (
    .clk(clk), .rstN(rstN), .branchTaken(branchTaken),
    .haltSeen(haltSeen), .flush(flush), .halted(hlt)
  );

  regFile u_regFile (
    .clk(clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .wrEn(wbValid), .wrAddr(wbAddr), .wrData(wbData), // Writeback register
    .rsData(rsData), .rtData(rtData)
  );

  decodeStage u_decodeStage (
    .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .flush(flush),
    .rsData(rsData), .rtData(rtData), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .exValid(exValid), .exOp(exOp), .exRd(exRd), .exRs(exRs), .exRt(exRt),
    .exA(exA), .exB(exB), .exImm(exImm), .exCond(exCond), .exTarget(exTarget)
  );

  ////////////////////
  // Back end
  ////////////////////
  executeStage u_executeStage (
    .clk(clk), .rstN(rstN), .exValid(exValid), .exOp(exOp), .exRd(exRd),
    .exRs(exRs), .exRt(exRt), .exA(exA), .exB(exB), .exImm(exImm),
    .exCond(exCond), .exTarget(exTarget), .branchTaken(branchTaken),
    .branchTarget(branchTarget), .haltSeen(haltSeen),
    .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
  );

endmodule

//--- verif/cpuTop_asserts.sv
`timescale 1ns/10ps

module cpuTop_asserts (
  input logic             clk,
  input logic             rstN,
  input cpuPkg::word_t    pc,
  input logic             hlt,
  input logic             wbValid,
  input cpuPkg::regAddr_t wbAddr
);

  int failCount = 0; // Failed assertions so far

  ////////////////////
  // Reset
  ////////////////////
  resetQuiet: assert property (@(posedge clk) !rstN |-> !wbValid)
    else begin
      $error("wbValid high while reset is held");
      failCount++;
    end

  pcFromZero: assert property (@(posedge clk) $rose(rstN) |-> pc == '0)
    else begin
      $error("pc not zero in the first cycle after reset");
      failCount++;
    end

  ////////////////////
  // Writeback and halt
  ////////////////////
  noZeroWrite: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbAddr != '0)
    else begin
      $error("writeback reported for register zero");
      failCount++;
    end

  haltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else begin
      $error("hlt dropped without reset");
      failCount++;
    end

  pcFrozen: assert property (@(posedge clk) disable iff (!rstN) hlt |=> $stable(pc))
    else begin
      $error("pc moved while halted");
      failCount++;
    end

endmodule

bind cpuTop cpuTop_asserts u_asserts (
  .clk(clk), .rstN(rstN), .pc(pc), .hlt(hlt), .wbValid(wbValid), .wbAddr(wbAddr)
);

//--- verif/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

  logic             clk = 1'b0;
  logic             rstN;
  cpuPkg::instr_u   instr;
  cpuPkg::word_t    pc;
  logic             hlt;
  logic             wbValid;
  cpuPkg::regAddr_t wbAddr;
  cpuPkg::word_t    wbData;

  cpuPkg::word_t mem [64];         // Instruction memory seen by the core
  cpuPkg::word_t progs [6][64];
  int            progLen [6] = '{default: 0};
  string         names [6] = '{"alu", "forward", "shift", "branch", "zeroReg", "halt"};
  int            expAddr [$];      // Expected writebacks, in order
  cpuPkg::word_t expData [$];
  string         testName;
  int            seen, checks, errors, passed, cycles, cycleLimit;
  logic [16:0]   lfsr = 17'd66982;

  always #2 clk = ~clk; // 4 ns period

  assign instr = mem[pc[5:0]]; // Combinational fetch

  cpuTop u_cpuTop (
    .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .hlt(hlt),
    .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
  );

  ////////////////////
  // Random bits and encoders
  ////////////////////
  function automatic logic [15:0] takeBits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]}; // Taps 17 and 14
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic cpuPkg::word_t regWord(cpuPkg::opcode_t op, int rd, int rs, int rt);
    cpuPkg::instr_u w;
    w.regView.opcode = op;
    w.regView.rd     = rd[3:0];
    w.regView.rs     = rs[3:0];
    w.regView.rt     = rt[3:0];
    return cpuPkg::word_t'(w);
  endfunction

  function automatic cpuPkg::word_t llbWord(int rd, logic [7:0] imm);
    return regWord(cpuPkg::LLB, rd, imm[7:4], imm[3:0]); // Immediate spans rs and rt
  endfunction

  function automatic cpuPkg::word_t branchWord(cpuPkg::cond_t c, int off);
    cpuPkg::instr_u w;
    w.brView.opcode = cpuPkg::BR;
    w.brView.cond   = c;
    w.brView.offset = off[8:0];
    return cpuPkg::word_t'(w);
  endfunction

  task automatic emit(input int t, input cpuPkg::word_t w);
    progs[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  ////////////////////
  // Program images
  ////////////////////
  task automatic buildPrograms();
    logic [3:0] amt;
    logic [1:0] choice;
    for (int i = 1; i <= 4; i++) begin
      emit(0, llbWord(i, 8'(takeBits(8))));
    end
    emit(0, regWord(cpuPkg::ADD, 5, 1, 2));
    emit(0, regWord(cpuPkg::SUB, 6, 3, 4));
    emit(0, regWord(cpuPkg::AND, 7, 1, 3));
    emit(0, regWord(cpuPkg::NOR, 8, 2, 4));
    emit(0, llbWord(9, 8'h7f));
    for (int i = 0; i < 9; i++) begin
      emit(0, regWord(cpuPkg::ADD, 9, 9, 9)); // Doubles until the sign bit wraps
    end
    // Dependent chain with operands one and two instructions old
    emit(1, llbWord(1, 8'(takeBits(8))));
    emit(1, llbWord(2, 8'(takeBits(8))));
    emit(1, regWord(cpuPkg::ADD, 3, 1, 2));
    emit(1, regWord(cpuPkg::SUB, 4, 3, 1));
    emit(1, regWord(cpuPkg::NOR, 5, 4, 3));
    emit(1, regWord(cpuPkg::ADD, 6, 5, 4));
    emit(1, regWord(cpuPkg::AND, 7, 6, 3));
    emit(1, regWord(cpuPkg::SUB, 7, 7, 5));
    emit(2, llbWord(1, 8'(takeBits(8))));
    emit(2, llbWord(2, 8'(takeBits(8)) | 8'h80)); // Negative operand
    for (int i = 0; i < 4; i++) begin
      amt = 4'(takeBits(4));
      emit(2, regWord(cpuPkg::SLL, 3, 1, amt));
      emit(2, regWord(cpuPkg::SRL, 4, 2, amt));
      emit(2, regWord(cpuPkg::SRA, 5, 2, amt));
      emit(2, regWord(cpuPkg::SRA, 6, 1, amt));
    end
    emit(3, llbWord(1, 8'(takeBits(8))));
    emit(3, llbWord(2, 8'(takeBits(8))));
    emit(3, llbWord(9, 8'h7f));
    emit(3, regWord(cpuPkg::SLL, 9, 9, 8)); // 0x7f00 overflows when doubled
    for (int c = 0; c < 8; c++) begin
      choice = 2'(takeBits(2));
      case (choice)
        2'd0:    emit(3, regWord(cpuPkg::SUB, 3, 1, 2));
        2'd1:    emit(3, regWord(cpuPkg::SUB, 3, 1, 1)); // Zero
        2'd2:    emit(3, regWord(cpuPkg::ADD, 3, 9, 9)); // Overflow and negative
        default: emit(3, regWord(cpuPkg::SUB, 3, 2, 1));
      endcase
      emit(3, branchWord(cpuPkg::cond_t'(c), 2));
      emit(3, llbWord(4, 8'(c + 1)));  // Skipped when taken
      emit(3, llbWord(5, 8'(c + 17)));
      emit(3, llbWord(6, 8'(c + 33))); // Always reached
    end
    emit(4, llbWord(1, 8'(takeBits(8))));
    emit(4, llbWord(0, 8'(takeBits(8))));
    emit(4, regWord(cpuPkg::ADD, 0, 1, 1));
    emit(4, regWord(cpuPkg::ADD, 2, 0, 1));
    emit(4, regWord(cpuPkg::NOR, 3, 0, 0));
    for (int t = 0; t < 5; t++) begin
      emit(t, regWord(cpuPkg::HLT, 0, 0, 0));
    end
    emit(5, llbWord(1, 8'(takeBits(8))));
    emit(5, regWord(cpuPkg::ADD, 2, 1, 1));
    emit(5, regWord(cpuPkg::SUB, 3, 2, 1));
    emit(5, regWord(cpuPkg::HLT, 0, 0, 0));
    emit(5, llbWord(4, 8'(takeBits(8))));   // Behind the HLT
    emit(5, regWord(cpuPkg::ADD, 5, 1, 1));
  endtask

  ////////////////////
  // Instruction-level model
  ////////////////////
  task automatic runModel(input int t);
    cpuPkg::word_t   regs [16];
    cpuPkg::instr_u  w;
    cpuPkg::opcode_t op;
    cpuPkg::word_t   a, b, res;
    logic            z, v, n, writes, take, done;
    int              p, sum;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    {z, v, n, done} = '0;
    p = 0;
    expAddr.delete();
    expData.delete();
    while (!done && p >= 0 && p < 64) begin
      w      = progs[t][p];
      op     = w.regView.opcode;
      a      = regs[w.regView.rs];
      b      = regs[w.regView.rt];
      writes = (op <= cpuPkg::LLB); // Opcodes 0 to 7 write rd
      sum    = 0;
      p++;
      case (op)
        cpuPkg::ADD: sum = $signed(a) + $signed(b);
        cpuPkg::SUB: sum = $signed(a) - $signed(b);
        cpuPkg::AND: sum = a & b;
        cpuPkg::NOR: sum = ~(a | b);
        cpuPkg::SLL: sum = a << w.regView.rt;
        cpuPkg::SRL: sum = a >> w.regView.rt;
        cpuPkg::SRA: sum = $signed(a) >>> w.regView.rt;
        cpuPkg::LLB: sum = $signed({w.regView.rs, w.regView.rt});
        cpuPkg::HLT: done = 1'b1;
        cpuPkg::BR: begin
          case (w.brView.cond)
            cpuPkg::NE: take = !z;
            cpuPkg::EQ: take = z;
            cpuPkg::GT: take = !z && !n;
            cpuPkg::LT: take = n;
            cpuPkg::GE: take = z || !n; // Greater or equal
            cpuPkg::LE: take = z || n;
            cpuPkg::OV: take = v;
            default:    take = 1'b1;
          endcase
          if (take) begin
            p = p + $signed(w.brView.offset); // From the next address
          end
        end
        default: sum = 0; // No-op
      endcase
      res = sum[15:0];
      if (writes && op != cpuPkg::LLB) begin
        z = (res == '0);
      end
      if (op == cpuPkg::ADD || op == cpuPkg::SUB) begin
        v = (sum != int'($signed(res))); // Result does not fit in 16 bits
        n = res[15];
      end
      if (writes && w.regView.rd != '0) begin
        regs[w.regView.rd] = res;
        expAddr.push_back(w.regView.rd);
        expData.push_back(res);
      end
    end
  endtask

  // Writeback compare on the falling edge
  always @(negedge clk) begin
    if (rstN && wbValid) begin
      checks++;
      assert (seen < expAddr.size()) else begin
        $display("%s: writeback to r%0d has no matching instruction in the model",
                 testName, wbAddr);
        errors++;
      end
      if (seen < expAddr.size()) begin
        assert (wbAddr == expAddr[seen] && wbData == expData[seen]) else begin
          $display("[FAIL] %s: expected r%0d=%h, actual r%0d=%h", testName,
                   expAddr[seen], expData[seen], wbAddr, wbData);
          errors++;
        end
      end
      seen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, %s never halted", cycles, testName);
      $display("Test failed");
      $finish;
    end
  end

  task automatic runTest(input int t);
    int   errBefore, assertBefore;
    logic ok;
    @(posedge clk);
    rstN <= 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] <= (i < progLen[t]) ? progs[t][i] : {4'd8, 6'd0, i[5:0]}; // No-op fill
    end
    runModel(t);
    seen         = 0;
    testName     = names[t];
    errBefore    = errors;
    assertBefore = u_cpuTop.u_asserts.failCount;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    while (!hlt) @(negedge clk);
    repeat (3) @(negedge clk); // Room for any stray report
    assert (seen == expAddr.size()) else begin
      $display("%s: %0d writebacks seen but the model expects %0d",
               testName, seen, expAddr.size());
      errors++;
    end
    ok = (errors == errBefore) && (u_cpuTop.u_asserts.failCount == assertBefore);
    passed += ok;
    $display("%-8s %0d writebacks, %s", testName, seen, ok ? "ok" : "FAILED");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int total;
    rstN = 1'b0;
    {seen, checks, errors, passed, cycles, cycleLimit, total} = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = {4'd8, 6'd0, i[5:0]};
    end
    buildPrograms();
    for (int t = 0; t < 6; t++) begin
      total += progLen[t];
    end
    cycleLimit = total * 3 + 20 * 6;
    for (int t = 0; t < 6; t++) begin
      runTest(t);
    end
    $display("%0d tests, %0d ok, %0d writebacks checked, %0d errors, %0d assertion failures",
             6, passed, checks, errors, u_cpuTop.u_asserts.failCount);
    if (errors == 0 && u_cpuTop.u_asserts.failCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- files.f
hw/cpuPkg.sv
hw/pcUnit.sv
hw/pipeControl.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/cpuTop.sv
verif/cpuTop_asserts.sv
verif/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/pcUnit.sv
      - hw/pipeControl.sv
      - hw/regFile.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/cpuTop.sv
  - target: test
    files:
      - verif/cpuTop_asserts.sv
      - verif/cpuTb.sv
